//--- design/mult_defs.svh
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// architectural register width
`define XLEN 32

// width of the full product carried through the stages
`define PROD_WIDTH 64

// pipeline depth, must divide PROD_WIDTH evenly
// each stage then handles PROD_WIDTH/MULT_STAGES multiplier bits
`define MULT_STAGES 4

// reorder buffer index
`define ROBN_WIDTH 5

// physical register number
`define PRN_WIDTH 6

`endif

//--- design/mult_pkg.sv
`default_nettype none

`include "mult_defs.svh"

package mult_pkg;

    // one register value
    typedef logic [`XLEN-1:0] data_t;

    // tags that follow an operation to the bus
    typedef logic [`ROBN_WIDTH-1:0] robn_t;
    typedef logic [`PRN_WIDTH-1:0]  prn_t;

    // rv32m multiply flavours, encoded as funct3[1:0]
    typedef enum logic [1:0] {
        mul    = 2'b00,
        mulh   = 2'b01,
        mulhsu = 2'b10,
        mulhu  = 2'b11
    } mult_func_t;

    // what the issue slot hands over, 77 bits
    typedef struct packed {
        mult_func_t func;
        data_t      rs1;
        data_t      rs2;
        robn_t      robn;
        prn_t       dest_prn;
    } mult_issue_t;

    // what goes out on the common data bus, 43 bits
    typedef struct packed {
        robn_t robn;
        prn_t  dest_prn;
        data_t result;
    } mult_cdb_t;

    // carried beside the arithmetic through every stage
    typedef struct packed {
        mult_func_t func;
        robn_t      robn;
        prn_t       dest_prn;
    } mult_tag_t;

    typedef struct packed {
        data_t hi;
        data_t lo;
    } product_halves_t;

    // stages add on the whole word, result select picks a half
    typedef union packed {
        logic [`PROD_WIDTH-1:0] whole;
        product_halves_t        halves;
    } product_u;

endpackage

`default_nettype wire

//--- design/mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_defs.svh"

// one slice of the shift-and-add multiplier
module mult_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 start,
    input  mult_pkg::product_u   prev_sum,
    input  logic [63:0]          mplier,
    input  logic [63:0]          mcand,
    input  mult_pkg::mult_tag_t  tag,
    output mult_pkg::product_u   product_sum,
    output logic [63:0]          next_mplier,
    output logic [63:0]          next_mcand,
    output mult_pkg::mult_tag_t  next_tag,
    output logic                 done
);

    localparam int SLICE = `PROD_WIDTH / `MULT_STAGES;

    logic [63:0] partial_product;

    // low slice of the multiplier times the already shifted multiplicand
    assign partial_product = mplier[SLICE-1:0] * mcand;

    // datapath registers, no reset needed
    always_ff @(posedge clock) begin
        if (advance) begin
            product_sum.whole <= prev_sum.whole + partial_product;
            next_mplier       <= mplier >> SLICE;  // next slice moves to the bottom
            next_mcand        <= mcand << SLICE;   // weight for the next slice
            next_tag          <= tag;
        end
    end

    // valid bit for this stage
    // a stall keeps it as is so the operation is not lost
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= start;
        end
    end

endmodule

`default_nettype wire

//--- design/mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_defs.svh"

// pipelined 32x32 multiplier returning the low or high word
module mult (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   advance,
    input  logic                   start,
    input  mult_pkg::mult_issue_t  op,
    output logic                   done,
    output mult_pkg::mult_cdb_t    out
);

    localparam int STAGES = `MULT_STAGES;

    logic [63:0] mcand;
    logic [63:0] mplier;
    mult_pkg::mult_tag_t in_tag;

    // chain wires, index i feeds stage i, index STAGES is the last output
    mult_pkg::product_u  sum_chain    [0:STAGES];
    logic [63:0]         mplier_chain [0:STAGES];
    logic [63:0]         mcand_chain  [0:STAGES];
    mult_pkg::mult_tag_t tag_chain    [0:STAGES];
    logic                done_chain   [0:STAGES];

    mult_pkg::product_u  final_sum;
    mult_pkg::mult_tag_t final_tag;

    // rs1 is signed for all but mulhu
    always_comb begin
        case (op.func)
            mult_pkg::mul, mult_pkg::mulh, mult_pkg::mulhsu: begin
                mcand = {{32{op.rs1[31]}}, op.rs1};
            end
            default: begin
                mcand = {32'b0, op.rs1};
            end
        endcase
    end

    // rs2 is signed only for mul and mulh
    always_comb begin
        case (op.func)
            mult_pkg::mul, mult_pkg::mulh: begin
                mplier = {{32{op.rs2[31]}}, op.rs2};
            end
            default: begin
                mplier = {32'b0, op.rs2};
            end
        endcase
    end

    assign in_tag.func     = op.func;
    assign in_tag.robn     = op.robn;
    assign in_tag.dest_prn = op.dest_prn;

    // head of the chain
    assign sum_chain[0].whole = '0;  // running sum starts at zero
    assign mplier_chain[0]    = mplier;
    assign mcand_chain[0]     = mcand;
    assign tag_chain[0]       = in_tag;
    assign done_chain[0]      = start;

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        mult_stage stage (
            .clock       (clock),
            .reset       (reset),
            .advance     (advance),
            .start       (done_chain[i]),  // previous done is the next start
            .prev_sum    (sum_chain[i]),
            .mplier      (mplier_chain[i]),
            .mcand       (mcand_chain[i]),
            .tag         (tag_chain[i]),
            .product_sum (sum_chain[i+1]),
            .next_mplier (mplier_chain[i+1]),
            .next_mcand  (mcand_chain[i+1]),
            .next_tag    (tag_chain[i+1]),
            .done        (done_chain[i+1])
        );
    end

    assign final_sum = sum_chain[STAGES];
    assign final_tag = tag_chain[STAGES];

    assign done         = done_chain[STAGES];
    assign out.robn     = final_tag.robn;
    assign out.dest_prn = final_tag.dest_prn;
    assign out.result   = (final_tag.func == mult_pkg::mul) ? final_sum.halves.lo
                                                            : final_sum.halves.hi;

endmodule

`default_nettype wire

//--- design/mult_cdb_port.sv
`timescale 1ns/1ps
`default_nettype none

// one-entry holding register between the multiplier and the cdb
// owns the pipeline stall decision
module mult_cdb_port (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 done,
    input  mult_pkg::mult_cdb_t  in,
    input  logic                 grant,
    output logic                 advance,
    output mult_pkg::mult_cdb_t  cdb,
    output logic                 cdb_valid
);

    logic load;
    logic drain;

    // room for a new result if empty, or the current one leaves now
    assign advance = !cdb_valid || grant;

    // a finished result moves in only while the pipe moves
    assign load = done && advance;

    // granted entry with nothing behind it
    assign drain = cdb_valid && grant && !load;

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else if (load) begin
            cdb_valid <= 1'b1;  // also covers grant plus refill
        end else if (drain) begin
            cdb_valid <= 1'b0;
        end
    end

    // payload, held while waiting for a grant
    always_ff @(posedge clock) begin
        if (load) begin
            cdb <= in;
        end
    end

endmodule

`default_nettype wire

//--- design/mult_fu.sv
`timescale 1ns/1ps
`default_nettype none

// multiply functional unit: pipeline plus bus port
module mult_fu (
    input  logic                   clock,
    input  logic                   reset,
    input  mult_pkg::mult_issue_t  issue,
    input  logic                   issue_valid,
    output logic                   issue_ready,
    output mult_pkg::mult_cdb_t    cdb,
    output logic                   cdb_valid,
    input  logic                   cdb_grant
);

    logic                advance;    // whole pipe moves together
    logic                pipe_done;
    mult_pkg::mult_cdb_t pipe_out;

    mult pipe (
        .clock   (clock),
        .reset   (reset),
        .advance (advance),
        .start   (issue_valid),
        .op      (issue),
        .done    (pipe_done),
        .out     (pipe_out)
    );

    mult_cdb_port port (
        .clock     (clock),
        .reset     (reset),
        .done      (pipe_done),
        .in        (pipe_out),
        .grant     (cdb_grant),
        .advance   (advance),
        .cdb       (cdb),
        .cdb_valid (cdb_valid)
    );

    // an issue is taken exactly when the pipe advances
    assign issue_ready = advance;

endmodule

`default_nettype wire

//--- bench/mult_fu_checker.sv
`timescale 1ns/1ps
`default_nettype none

// handshake properties of the multiply unit, bound into mult_fu
module mult_fu_checker (
    input logic                clock,
    input logic                reset,
    input logic                issue_ready,
    input logic                pipe_done,
    input mult_pkg::mult_cdb_t pipe_out,
    input mult_pkg::mult_cdb_t cdb,
    input logic                cdb_valid,
    input logic                cdb_grant
);

    int failures;  // read by the testbench at the end of the run

    initial begin
        failures = 0;
    end

    // a result waiting for its grant stays put
    cdb_held: assert property (@(posedge clock) disable iff (reset)
        cdb_valid && !cdb_grant |=> cdb_valid && $stable(cdb))
    else begin
        $error("cdb changed or dropped while waiting for a grant");
        failures++;
    end

    // denied grant blocks the issue side and the whole pipe holds its state
    stall_freezes_pipe: assert property (@(posedge clock) disable iff (reset)
        cdb_valid && !cdb_grant |=>
            !$past(issue_ready) && $stable(pipe_done) && $stable(pipe_out))
    else begin
        $error("issue taken or pipeline moved while the bus port is stalled");
        failures++;
    end

    cdb_idle_after_reset: assert property (@(posedge clock)
        reset |=> !cdb_valid)
    else begin
        $error("cdb_valid high in the cycle after reset");
        failures++;
    end

    cdb_known: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> !$isunknown(cdb))
    else begin
        $error("cdb carries unknown bits while valid");
        failures++;
    end

endmodule

bind mult_fu mult_fu_checker handshake_checks (
    .clock       (clock),
    .reset       (reset),
    .issue_ready (issue_ready),
    .pipe_done   (pipe_done),
    .pipe_out    (pipe_out),
    .cdb         (cdb),
    .cdb_valid   (cdb_valid),
    .cdb_grant   (cdb_grant)
);

`default_nettype wire

//--- bench/mult_fu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mult_defs.svh"

module mult_fu_tb;

    localparam int STAGES     = `MULT_STAGES;
    localparam int BURST_OPS  = 64;   // every func times every corner pair
    localparam int RANDOM_OPS = 336;
    localparam int TIMEOUT_NS = 400 * (`MULT_STAGES + 10) * 8 * 4;

    logic                  clock;
    logic                  reset;
    mult_pkg::mult_issue_t issue;
    logic                  issue_valid;
    logic                  issue_ready;
    mult_pkg::mult_cdb_t   cdb;
    logic                  cdb_valid;
    logic                  cdb_grant;

    integer          seed = 32'h96d2;
    int              error_count = 0;
    int              checks_done = 0;
    int              accepted = 0;
    int              results = 0;
    int              cycle = 0;
    logic            burst_phase;  // ops taken now must meet the exact latency
    mult_pkg::robn_t next_robn;

    // reference model, one entry per accepted issue, oldest first
    mult_pkg::mult_cdb_t  exp_q[$];
    mult_pkg::mult_func_t func_q[$];
    int                   accept_cycle_q[$];
    bit                   timed_q[$];

    mult_fu DUT (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .cdb         (cdb),
        .cdb_valid   (cdb_valid),
        .cdb_grant   (cdb_grant)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic mult_pkg::data_t corner_value(input int idx);
        case (idx)
            0:       corner_value = 32'h0000_0000;
            1:       corner_value = 32'h0000_0001;
            2:       corner_value = 32'hffff_ffff;
            default: corner_value = 32'h8000_0000;  // most negative
        endcase
    endfunction

    function automatic mult_pkg::data_t random_operand();
        logic [31:0] pick;
        pick = $random(seed);
        if (pick[1:0] == 2'b00) begin  // about one in four
            random_operand = corner_value(pick[3:2]);
        end else begin
            random_operand = $random(seed);
        end
    endfunction

    function automatic mult_pkg::mult_issue_t random_op(input mult_pkg::robn_t robn);
        mult_pkg::mult_issue_t op;
        logic [31:0]           r;
        r           = $random(seed);
        op.func     = mult_pkg::mult_func_t'(r[1:0]);
        op.rs1      = random_operand();
        op.rs2      = random_operand();
        op.robn     = robn;
        op.dest_prn = mult_pkg::prn_t'(r >> 4);
        return op;
    endfunction

    // rv32m rules: rs1 is the left operand, mulhsu treats rs2 as unsigned
    function automatic mult_pkg::data_t expected_result(input mult_pkg::mult_func_t func,
                                                         input mult_pkg::data_t a,
                                                         input mult_pkg::data_t b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     product;
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        case (func)
            mult_pkg::mul:    product = sa * sb;
            mult_pkg::mulh:   product = sa * sb;
            mult_pkg::mulhsu: product = sa * ub;  // exact modulo 2**64
            default:          product = ua * ub;
        endcase
        if (func == mult_pkg::mul) begin
            expected_result = product[31:0];
        end else begin
            expected_result = product[63:32];
        end
    endfunction

    function automatic string func_name(input mult_pkg::mult_func_t func);
        case (func)
            mult_pkg::mul:    func_name = "mul";
            mult_pkg::mulh:   func_name = "mulh";
            mult_pkg::mulhsu: func_name = "mulhsu";
            default:          func_name = "mulhu";
        endcase
    endfunction

    // values print as robn, dest_prn and result
    task automatic check_cdb(input string name,
                             input mult_pkg::mult_cdb_t expected,
                             input mult_pkg::mult_cdb_t actual);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s expected {%0d %0d %h} actual {%0d %0d %h}", name,
                     expected.robn, expected.dest_prn, expected.result,
                     actual.robn, actual.dest_prn, actual.result);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks_done++;
        if (actual != expected) begin
            error_count++;
            $display("error: %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks_done++;
        if (actual != expected) begin
            error_count++;
            $display("error: %s expected %0d cycles actual %0d cycles", name, expected, actual);
        end
    endtask

    // grant must already be held high by the caller
    task automatic wait_for_drain();
        @(posedge clock);
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (STAGES + 4) @(posedge clock);  // room for a stray duplicate to show up
    endtask

    // sample both handshakes on the edge, before any new drive lands
    always @(posedge clock) begin : monitor
        mult_pkg::mult_cdb_t  predicted;
        mult_pkg::mult_func_t func;
        int                   taken_at;
        bit                   timed;
        if (!reset) begin
            cycle = cycle + 1;
            if (cdb_valid && cdb_grant) begin
                results = results + 1;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("result robn %0d appeared on the bus with no issue pending",
                             cdb.robn);
                end else begin
                    predicted = exp_q.pop_front();
                    func      = func_q.pop_front();
                    taken_at  = accept_cycle_q.pop_front();
                    timed     = timed_q.pop_front();
                    check_cdb(func_name(func), predicted, cdb);
                    if (timed) begin
                        check_latency("burst latency", STAGES + 1, cycle - taken_at);
                    end
                end
            end
            if (issue_valid && issue_ready) begin
                accepted           = accepted + 1;
                predicted.robn     = issue.robn;
                predicted.dest_prn = issue.dest_prn;
                predicted.result   = expected_result(issue.func, issue.rs1, issue.rs2);
                exp_q.push_back(predicted);
                func_q.push_back(issue.func);
                accept_cycle_q.push_back(cycle);
                timed_q.push_back(burst_phase);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        mult_pkg::mult_issue_t op;
        logic [31:0]           r;
        int                    sent;
        reset       = 1'b1;
        issue       = '0;
        issue_valid = 1'b0;
        cdb_grant   = 1'b0;
        burst_phase = 1'b0;
        next_robn   = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        cdb_grant   <= 1'b1;  // no stalls for the whole burst
        burst_phase <= 1'b1;

        // back to back corner operands, one accepted per cycle
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    @(posedge clock);
                    op.func     = mult_pkg::mult_func_t'(f);
                    op.rs1      = corner_value(i);
                    op.rs2      = corner_value(j);
                    op.robn     = next_robn;
                    op.dest_prn = mult_pkg::prn_t'($random(seed));
                    next_robn   = next_robn + 1'b1;
                    issue       <= op;
                    issue_valid <= 1'b1;
                end
            end
        end
        @(posedge clock);
        issue_valid <= 1'b0;
        burst_phase <= 1'b0;
        wait_for_drain();

        // random issue and grant, an offer is held until it is taken
        sent = 0;
        while (sent < RANDOM_OPS) begin
            @(posedge clock);
            if (issue_valid && issue_ready) begin
                sent++;
            end
            r = $random(seed);
            cdb_grant <= (r % 10) < 6;
            if (!issue_valid || issue_ready) begin
                r = $random(seed);
                if (sent < RANDOM_OPS && (r % 10) < 7) begin
                    issue       <= random_op(next_robn);
                    issue_valid <= 1'b1;
                    next_robn   = next_robn + 1'b1;
                end else begin
                    issue_valid <= 1'b0;
                end
            end
        end
        issue_valid <= 1'b0;
        cdb_grant   <= 1'b1;
        wait_for_drain();

        check_count("accepted count", BURST_OPS + RANDOM_OPS, accepted);
        check_count("result count", accepted, results);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks_done, error_count, DUT.handshake_checks.failures);
        if (error_count == 0 && DUT.handshake_checks.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/mult_pkg.sv
design/mult_stage.sv
design/mult.sv
design/mult_cdb_port.sv
design/mult_fu.sv
bench/mult_fu_checker.sv
bench/mult_fu_tb.sv
